/* hdl/mem_sys_pkg.sv */
// Shared sizes and types for the fetch and memory front end
// Memory bus command and access size enums
// Memory word union, request, response and fetch output structs

package mem_sys_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int XLEN         = 32;
    localparam int MEM_TAG_W    = 4;   // Tag 0 means not accepted
    localparam int BLOCK_OFF_W  = 3;   // 8-byte blocks
    localparam int ICACHE_LINES = 32;
    localparam int ICACHE_IDX_W = 5;
    localparam int ICACHE_TAG_W = XLEN - ICACHE_IDX_W - BLOCK_OFF_W;

    //////////////////////////////
    // Bus encodings
    //////////////////////////////
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    // One memory word, seen whole or as two instructions
    typedef union packed {
        logic [63:0]           dword;
        logic [1:0][XLEN-1:0]  inst;   // inst[0] at the lower address
    } mem_word_t;

    //////////////////////////////
    // Bundles
    //////////////////////////////
    typedef struct packed {
        bus_command_t    command;
        logic [XLEN-1:0] addr;
        mem_word_t       data;   // Store data
        mem_size_t       size;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_TAG_W-1:0] response;   // Accept tag for this cycle's request
        logic [MEM_TAG_W-1:0] tag;        // Ticket of the returning load
        mem_word_t            data;
    } mem_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_out_t;

endpackage

/* hdl/fetch_unit.sv */
// Fetch sequencing
// Program counter with redirect, stall and advance on a delivered instruction

`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          stall,           // Holds the PC
    input  logic                          redirect_valid,  // One-cycle pulse
    input  logic [mem_sys_pkg::XLEN-1:0]  redirect_pc,
    input  mem_sys_pkg::fetch_out_t       fetch,           // From the icache
    output logic [mem_sys_pkg::XLEN-1:0]  pc
);
    import mem_sys_pkg::*;

    logic [XLEN-1:0] pc_next;
    logic            advance;

    // Only move on once the current instruction was delivered
    assign advance = fetch.valid && !stall;

    //////////////////////////////
    // Next PC
    //////////////////////////////
    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;       // Redirect wins over everything
        end else if (advance) begin
            pc_next = pc + XLEN'(4);
        end else begin
            pc_next = pc;                // Miss or stall
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    // An aligned PC stays aligned unless a misaligned target is loaded
    a_pc_aligned: assert property (
        @(posedge clock) disable iff (!rst_n)
        (pc[1:0] == 2'b00 && (!redirect_valid || redirect_pc[1:0] == 2'b00))
            |=> (pc[1:0] == 2'b00)
    ) else $error("fetch_unit: PC lost 4-byte alignment");

endmodule

/* hdl/icache.sv */
// Direct-mapped instruction cache with 8-byte blocks
// Valid, tag and data arrays, combinational hit path
// Miss request with ticket tracking and fill on the matching return tag

`timescale 1ns/1ps

module icache (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [mem_sys_pkg::XLEN-1:0]  pc,
    input  mem_sys_pkg::mem_rsp_t         mem_rsp,   // Arbiter copy of the response
    output mem_sys_pkg::mem_req_t         mem_req,
    output mem_sys_pkg::fetch_out_t       fetch
);
    import mem_sys_pkg::*;

    // PC fields
    logic [ICACHE_TAG_W-1:0] pc_tag;
    logic [ICACHE_IDX_W-1:0] pc_idx;
    logic                    word_sel;   // Which half of the block

    // Line storage
    logic [ICACHE_LINES-1:0] valid_q;
    logic [ICACHE_TAG_W-1:0] tag_mem [ICACHE_LINES];
    mem_word_t               data_mem [ICACHE_LINES];

    // Outstanding miss
    logic                    pending_q;
    logic [MEM_TAG_W-1:0]    ticket_q;
    logic [XLEN-1:0]         miss_addr_q;   // Block address of the miss

    logic                    hit;
    logic                    accepted;
    logic                    fill;
    logic [ICACHE_IDX_W-1:0] fill_idx;
    logic [ICACHE_TAG_W-1:0] fill_tag;

    assign pc_tag   = pc[XLEN-1 -: ICACHE_TAG_W];
    assign pc_idx   = pc[BLOCK_OFF_W +: ICACHE_IDX_W];
    assign word_sel = pc[2];

    assign fill_tag = miss_addr_q[XLEN-1 -: ICACHE_TAG_W];
    assign fill_idx = miss_addr_q[BLOCK_OFF_W +: ICACHE_IDX_W];

    //////////////////////////////
    // Lookup
    //////////////////////////////
    assign hit = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);

    always_comb begin
        fetch.valid = hit;
        fetch.pc    = pc;
        fetch.inst  = data_mem[pc_idx].inst[word_sel];
    end

    //////////////////////////////
    // Miss request
    //////////////////////////////
    always_comb begin
        mem_req.command = BUS_NONE;
        mem_req.addr    = '0;
        mem_req.data    = '0;                // Loads carry no data
        mem_req.size    = DOUBLE;
        if (!hit && !pending_q) begin
            mem_req.command = BUS_LOAD;
            mem_req.addr    = {pc[XLEN-1:BLOCK_OFF_W], {BLOCK_OFF_W{1'b0}}};
        end
    end

    // Nonzero accept tag becomes the ticket
    assign accepted = (mem_req.command != BUS_NONE) && (mem_rsp.response != '0);
    assign fill     = pending_q && (mem_rsp.tag == ticket_q);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= '0;
            pending_q <= 1'b0;
            ticket_q  <= '0;
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
            pending_q         <= 1'b0;
            ticket_q          <= '0;
        end else if (accepted) begin
            pending_q <= 1'b1;
            ticket_q  <= mem_rsp.response;
        end
    end

    // Arrays and miss address
    always_ff @(posedge clock) begin
        if (accepted) begin
            miss_addr_q <= mem_req.addr;
        end
        if (fill) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= mem_rsp.data;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    // A held ticket is the memory's accept tag, never zero
    a_ticket_nonzero: assert property (
        @(posedge clock) disable iff (!rst_n)
        pending_q |-> (ticket_q != '0)
    ) else $error("icache: held ticket is zero");

    a_no_req_while_pending: assert property (
        @(posedge clock) disable iff (!rst_n)
        pending_q |-> (mem_req.command == BUS_NONE)
    ) else $error("icache: request issued while a ticket is held");

endmodule

/* hdl/cache_arbiter.sv */
// Memory port arbiter between instruction and data caches
// Data side has fixed priority, losing side sees a zero accept tag

`timescale 1ns/1ps

module cache_arbiter (
    input  mem_sys_pkg::mem_req_t  icache_req,
    input  mem_sys_pkg::mem_req_t  dcache_req,
    input  mem_sys_pkg::mem_rsp_t  mem_rsp,
    output mem_sys_pkg::mem_req_t  mem_req,
    output mem_sys_pkg::mem_rsp_t  icache_rsp,
    output mem_sys_pkg::mem_rsp_t  dcache_rsp
);
    import mem_sys_pkg::*;

    logic dcache_active;

    assign dcache_active = (dcache_req.command != BUS_NONE);

    //////////////////////////////
    // Request select
    //////////////////////////////
    always_comb begin
        if (dcache_active) begin
            mem_req.command    = dcache_req.command;
            mem_req.addr       = dcache_req.addr;
            mem_req.data.dword = dcache_req.data.dword;   // Store data forwarded whole
            mem_req.size       = dcache_req.size;
        end else begin
            mem_req = icache_req;                         // Load or idle
        end
    end

    //////////////////////////////
    // Response gating
    //////////////////////////////
    // Return tag and data go to both sides, each matches its own ticket
    always_comb begin
        icache_rsp = mem_rsp;
        dcache_rsp = mem_rsp;
        if (dcache_active) begin
            icache_rsp.response = '0;   // Refused, icache retries
        end else begin
            dcache_rsp.response = '0;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    // Data side owns the port whenever it is active
    always_comb begin
        if (dcache_active) begin
            a_dcache_owns_port: assert (mem_req == dcache_req)
                else $error("cache_arbiter: dcache request not on the memory port");
        end
    end

endmodule

/* hdl/fetch_mem_top.sv */
// Top level of the fetch and memory front end
// Fetch unit, instruction cache and memory port arbiter

`timescale 1ns/1ps

module fetch_mem_top (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          redirect_valid,
    input  logic [mem_sys_pkg::XLEN-1:0]  redirect_pc,
    input  mem_sys_pkg::mem_req_t         dcache_req,
    input  mem_sys_pkg::mem_rsp_t         mem_rsp,
    output mem_sys_pkg::mem_req_t         mem_req,
    output mem_sys_pkg::mem_rsp_t         dcache_rsp,
    output mem_sys_pkg::fetch_out_t       fetch
);
    import mem_sys_pkg::*;

    logic [XLEN-1:0] pc;
    mem_req_t        icache_req;
    mem_rsp_t        icache_rsp;   // Accept tag gated by the arbiter

    fetch_unit u_fetch (
        .clock          (clock),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch          (fetch),          // Fed back to advance the PC
        .pc             (pc)
    );

    icache u_icache (.clock(clock), .rst_n(rst_n), .pc(pc), .mem_rsp(icache_rsp),
                     .mem_req(icache_req), .fetch(fetch));

    cache_arbiter u_arbiter (.icache_req(icache_req), .dcache_req(dcache_req),
                             .mem_rsp(mem_rsp), .mem_req(mem_req),
                             .icache_rsp(icache_rsp), .dcache_rsp(dcache_rsp));

endmodule

/* test/tb_checker.sv */
// Checker for the fetch front end
// Reference rules for fetch data, PC sequence, arbitration and response gating
// Reset state and second-pass hit checks, error and check counters

`timescale 1ns/1ps

module tb_checker (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [1:0]                    phase,
    input  logic                          stall,
    input  logic                          redirect_valid,
    input  logic [mem_sys_pkg::XLEN-1:0]  redirect_pc,
    input  mem_sys_pkg::mem_req_t         dcache_req,
    input  mem_sys_pkg::mem_rsp_t         mem_rsp,
    input  mem_sys_pkg::mem_req_t         mem_req,
    input  mem_sys_pkg::mem_rsp_t         dcache_rsp,
    input  mem_sys_pkg::fetch_out_t       fetch,
    output int                            errors,
    output int                            checks
);
    import mem_sys_pkg::*;

    logic [XLEN-1:0]      model_pc;
    int                   stuck_cycles;   // No delivery and no redirect
    logic                 first_cycle;
    logic                 first_req_seen;
    int                   cycle_errors;
    int                   cycle_checks;
    logic [MEM_TAG_W-1:0] exp_accept;

    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ (addr >> 11) ^ 32'h5bd1e995;
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("FAILED at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        cycle_errors++;
    endtask

    task automatic rule_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        cycle_errors++;
    endtask

    // Sampled on the rising edge, so all values belong to the cycle just ended
    always @(posedge clock) begin
        cycle_errors = 0;
        cycle_checks = 0;
        if (!rst_n) begin
            model_pc       <= '0;
            stuck_cycles   <= 0;
            first_cycle    <= 1'b1;
            first_req_seen <= 1'b0;
        end else begin
            if (first_cycle && fetch.valid) value_error("fetch.valid", 128'(1), 128'(0));
            first_cycle <= 1'b0;
            if (!first_req_seen && mem_req.command != BUS_NONE) begin
                first_req_seen <= 1'b1;
                if (mem_req.command != BUS_LOAD || mem_req.addr != '0) begin
                    rule_error($sformatf("first memory request is command %0d at 0x%08h, %s",
                                         mem_req.command, mem_req.addr, "not a load of block 0"));
                end
            end

            //////////////////////////////
            // PC sequence and fetch data
            //////////////////////////////
            cycle_checks++;
            if (fetch.pc != model_pc) value_error("fetch.pc", 128'(fetch.pc), 128'(model_pc));
            if (redirect_valid) begin
                model_pc <= redirect_pc;
            end else if (fetch.valid && !stall) begin
                model_pc <= model_pc + 32'd4;
            end
            if (fetch.valid || redirect_valid) begin
                stuck_cycles <= 0;
            end else begin
                stuck_cycles <= stuck_cycles + 1;
                if (stuck_cycles == 199) begin
                    rule_error($sformatf("timeout, PC 0x%08h delivered nothing for 200 cycles",
                                         fetch.pc));
                end
            end
            if (fetch.valid) begin
                cycle_checks++;
                if (fetch.inst != word_hash(fetch.pc)) begin
                    value_error("fetch.inst", 128'(fetch.inst), 128'(word_hash(fetch.pc)));
                end
            end

            //////////////////////////////
            // Memory port
            //////////////////////////////
            cycle_checks++;
            if (dcache_req.command != BUS_NONE) begin
                if (mem_req != dcache_req) value_error("mem_req", 128'(mem_req), 128'(dcache_req));
            end else if (mem_req.command == BUS_LOAD) begin
                // Icache load must be the block of a missing PC
                if (fetch.valid || mem_req.addr != {fetch.pc[31:3], 3'b000}) begin
                    rule_error($sformatf("icache load of 0x%08h does not match a miss at 0x%08h",
                                         mem_req.addr, fetch.pc));
                end
            end else if (mem_req.command != BUS_NONE) begin
                rule_error($sformatf("icache drove bus command %0d", mem_req.command));
            end

            cycle_checks++;
            exp_accept = (dcache_req.command != BUS_NONE) ? mem_rsp.response : '0;
            if (dcache_rsp.response != exp_accept) begin
                value_error("dcache_rsp.response", 128'(dcache_rsp.response), 128'(exp_accept));
            end
            if (dcache_rsp.tag != mem_rsp.tag) begin
                value_error("dcache_rsp.tag", 128'(dcache_rsp.tag), 128'(mem_rsp.tag));
            end
            if (dcache_rsp.data != mem_rsp.data) begin
                value_error("dcache_rsp.data", 128'(dcache_rsp.data), 128'(mem_rsp.data));
            end

            // Lines 0x00 to 0x7c were filled by the first pass
            if (phase == 2'd1 && mem_req.command == BUS_LOAD && mem_req.addr < 32'h80) begin
                rule_error($sformatf("memory load of 0x%08h during the second pass",
                                     mem_req.addr));
            end
            errors <= errors + cycle_errors;
            checks <= checks + cycle_checks;
        end
    end

endmodule

/* test/tb_top.sv */
// Testbench top for the fetch and memory front end
// Clock, reset, LCG stimulus and a memory model with tickets and delayed returns

`timescale 1ns/1ps

module tb_top;
    import mem_sys_pkg::*;

    logic            clock;
    logic            rst_n;
    logic            stall;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    mem_req_t        dcache_req;
    mem_rsp_t        mem_rsp;
    mem_req_t        mem_req;
    mem_rsp_t        dcache_rsp;
    fetch_out_t      fetch;
    logic [1:0]      phase;          // 0 first pass, 1 second pass, 2 random
    int              errors;
    int              checks;

    logic [31:0]          lcg_state;
    logic [3:0]           cycle;         // Return slot of the current cycle
    logic [3:0]           slot;
    logic [15:0]          slot_busy;     // At most one return per cycle
    logic [MEM_TAG_W-1:0] slot_tag [16];
    logic [XLEN-1:0]      slot_addr [16];
    logic [MEM_TAG_W-1:0] next_ticket;
    logic                 stall_en;
    logic                 traffic_en;
    logic                 restart_now;   // Redirect to PC 0 next cycle
    logic                 hung;

    fetch_mem_top dut_i (.*);
    tb_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ (addr >> 11) ^ 32'h5bd1e995;
    endfunction

    //////////////////////////////
    // Memory model and input drive, one clock cycle
    //////////////////////////////
    task automatic step_cycle();
        logic [31:0] a;
        @(posedge clock);
        cycle = cycle + 4'd1;
        lcg_state = lcg_next(lcg_state);
        // Load accepted last cycle comes back 1 to 8 cycles later
        if (rst_n && mem_req.command == BUS_LOAD && mem_rsp.response != '0) begin
            slot = cycle + {1'b0, lcg_state[30:28]};
            while (slot_busy[slot] && slot != cycle - 4'd1) begin
                slot = slot + 4'd1;
            end
            slot_busy[slot] = 1'b1;
            slot_tag[slot]  = mem_rsp.response;
            slot_addr[slot] = mem_req.addr;
            next_ticket     = (next_ticket == 4'hf) ? 4'h1 : next_ticket + 4'h1;
        end
        if (slot_busy[cycle]) begin
            a = slot_addr[cycle];
            mem_rsp.tag        <= slot_tag[cycle];
            mem_rsp.data.dword <= {word_hash(a + 32'd4), word_hash(a)};
            slot_busy[cycle]    = 1'b0;
        end else begin
            mem_rsp.tag        <= '0;
            mem_rsp.data.dword <= {lcg_state, ~lcg_state};   // Idle bus noise
        end
        mem_rsp.response <= (lcg_state[27:26] == 2'b00) ? '0 : next_ticket;  // 1 in 4 refused

        lcg_state = lcg_next(lcg_state);
        stall <= stall_en && (lcg_state[31:30] == 2'b00);
        if (restart_now) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= '0;
            restart_now     = 1'b0;
        end else begin
            redirect_valid <= traffic_en && (lcg_state[29:25] == 5'd0);
            redirect_pc    <= {22'h0, lcg_state[24:17], 2'b00};   // 1 KiB, four times the cache
        end

        lcg_state = lcg_next(lcg_state);
        dcache_req.command <= BUS_NONE;
        if (traffic_en && lcg_state[31:30] == 2'b00) begin
            dcache_req.command <= lcg_state[29] ? BUS_STORE : BUS_LOAD;
        end
        dcache_req.addr       <= {lcg_state[28:0], 3'b000};
        dcache_req.size       <= mem_size_t'(lcg_state[1:0]);
        dcache_req.data.dword <= {lcg_state, lcg_next(lcg_state)};
    endtask

    // Bounded wait for the fetch PC to reach a target
    task automatic run_until_pc(input logic [31:0] target, input int limit);
        int n;
        n = 0;
        while (!hung && fetch.pc < target) begin
            if (n == limit) begin
                $display("Timeout: PC stuck at 0x%08h, 0x%08h not reached in %0d cycles",
                         fetch.pc, target, limit);
                hung = 1'b1;
            end else begin
                step_cycle();
                n++;
            end
        end
    endtask

    task automatic report_test(input string name, input int base);
        $display("test %s: %0d errors", name, errors - base);
    endtask

    initial begin
        int base;
        lcg_state       = 32'h402b5d7a;
        cycle           = '0;
        slot            = '0;
        slot_busy       = '0;
        next_ticket     = 4'h1;
        stall_en        = 1'b0;
        traffic_en      = 1'b0;
        restart_now     = 1'b0;
        hung            = 1'b0;
        phase          <= 2'd0;
        rst_n          <= 1'b0;
        stall          <= 1'b0;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        dcache_req     <= '0;
        mem_rsp        <= '0;
        repeat (4) step_cycle();
        rst_n <= 1'b1;

        // First pass over 0x00 to 0x7c fills 16 lines
        base     = errors;
        stall_en = 1'b1;
        run_until_pc(32'h80, 3000);
        step_cycle();
        report_test("first pass from reset", base);

        if (!hung) begin
            base        = errors;
            restart_now = 1'b1;
            step_cycle();
            step_cycle();
            phase <= 2'd1;              // PC is back at 0 from here
            run_until_pc(32'h80, 1000);
            step_cycle();
            phase <= 2'd2;
            report_test("second pass hits", base);
        end

        if (!hung) begin
            base       = errors;
            traffic_en = 1'b1;
            repeat (3000) step_cycle();
            traffic_en = 1'b0;
            repeat (2) step_cycle();
            report_test("random stall, redirect and dcache traffic", base);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (!hung && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mem_sys_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/cache_arbiter.sv
hdl/fetch_mem_top.sv
test/tb_checker.sv
test/tb_top.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

TOP := tb_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

obj_dir/V$(TOP): compile.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
